// File: Bender.yml
package:
  name: lsq

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsq_pkg.sv
      - logic/queue_ptr_counter.sv
      - logic/mem_issue_fsm.sv
      - logic/load_queue.sv
      - logic/store_queue.sv
      - logic/result_arbiter.sv
      - logic/lsq_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/lsq_tb.sv

// File: dv/lsq_tb.sv
/*
 * Load/store queue testbench
 * Drives dispatch, CDB, commit and flush into the LSQ, models memory and
 * checks every result against a program-order reference
 */
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_tb
	import lsq_pkg::*;
();
	localparam int CLK_PERIOD = 100;
	localparam int ITEMS      = 20;     // Items dispatched over all tests
	localparam int ROB_N      = 1 << `LSQ_ROB_W;

	typedef struct packed {
		logic [`LSQ_XLEN-1:0] addr;
		logic [`LSQ_XLEN-1:0] data;
	} store_rec_s;

	logic          clock;
	logic          reset;
	lsq_dispatch_s dispatch;
	logic          dispatch_ready;
	lsq_cdb_s      cdb;
	logic          commit_store;
	logic          flush;
	lsq_result_s   result;
	lsq_mem_req_s  mem_req;
	logic          mem_req_ready;
	lsq_mem_rsp_s  mem_rsp;

	logic [`LSQ_XLEN-1:0]  mem [logic [`LSQ_XLEN-1:0]];        // Memory behind the DUT
	logic [`LSQ_XLEN-1:0]  ref_mem [logic [`LSQ_XLEN-1:0]];    // Committed program state
	store_rec_s            spec_q [$];                          // Uncommitted stores, oldest first
	logic                  exp_valid [ROB_N];
	logic [`LSQ_XLEN-1:0]  exp_data [ROB_N];
	logic [`LSQ_TAG_W-1:0] exp_tag [ROB_N];
	logic                  exp_lda [ROB_N];
	logic                  exp_is_load [ROB_N];
	time                   exp_time [ROB_N];
	int                    value_errs = 0;
	int                    other_errs = 0;
	int                    mem_writes = 0;
	logic [31:0]           lcg_state = 32'hb0e6;
	logic                  hold_low;            // Forces mem_req_ready low
	logic [`LSQ_ROB_W-1:0] next_rob = '0;

	lsq_top u_dut (
		.clock          (clock),
		.reset          (reset),
		.dispatch       (dispatch),
		.dispatch_ready (dispatch_ready),
		.cdb            (cdb),
		.commit_store   (commit_store),
		.flush          (flush),
		.result         (result),
		.mem_req        (mem_req),
		.mem_req_ready  (mem_req_ready),
		.mem_rsp        (mem_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers and reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Contents of a location never written
	function automatic logic [`LSQ_XLEN-1:0] fill_value(logic [`LSQ_XLEN-1:0] addr);
		return {addr[31:0], addr[63:32]} ^ (addr * 64'h9e37_79b9_7f4a_7c15);
	endfunction

	function automatic logic [`LSQ_XLEN-1:0] read_mem(logic [`LSQ_XLEN-1:0] addr);
		return mem.exists(addr) ? mem[addr] : fill_value(addr);
	endfunction

	function automatic logic [`LSQ_XLEN-1:0] ref_result(lsq_op_e op,
			logic [`LSQ_XLEN-1:0] base, logic [`LSQ_XLEN-1:0] off);
		logic [`LSQ_XLEN-1:0] addr;
		logic [`LSQ_XLEN-1:0] val;
		addr = base + off;
		if (op == LDA) return addr;
		val = ref_mem.exists(addr) ? ref_mem[addr] : fill_value(addr);
		foreach (spec_q[i]) begin
			if (spec_q[i].addr == addr) val = spec_q[i].data;  // Youngest older store wins
		end
		return val;
	endfunction

	function automatic int pending_results();
		int cnt;
		cnt = 0;
		for (int i = 0; i < ROB_N; i++) begin
			if (exp_valid[i]) cnt++;
		end
		return cnt;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clock);
			#10;
		end
	endtask

	// Holds the item on dispatch until an edge with dispatch_ready high
	task automatic dispatch_item(input lsq_dispatch_s d, input logic [`LSQ_XLEN-1:0] expect_val);
		d.rob_idx  = next_rob;
		d.dest_tag = {1'b1, next_rob};
		next_rob++;
		dispatch = d;
		@(posedge clock);
		while (dispatch_ready !== 1'b1) @(posedge clock);
		if (d.op != STORE) begin
			exp_valid[d.rob_idx]   = 1'b1;
			exp_data[d.rob_idx]    = expect_val;
			exp_tag[d.rob_idx]     = d.dest_tag;
			exp_lda[d.rob_idx]     = (d.op == LDA);
			exp_is_load[d.rob_idx] = (d.op == LOAD);
			exp_time[d.rob_idx]    = $time;
		end
		#10;
		dispatch.op = NONE;
	endtask

	task automatic send_lda(input logic [`LSQ_XLEN-1:0] base, input logic [`LSQ_XLEN-1:0] off);
		lsq_dispatch_s d;
		d              = '0;
		d.op           = LDA;
		d.base         = base;
		d.offset.data  = off;
		d.offset_ready = 1'b1;
		d.data_ready   = 1'b1;
		dispatch_item(d, ref_result(LDA, base, off));
	endtask

	// A waiting offset carries its tag, off is the value broadcast later
	task automatic send_load(input logic [`LSQ_XLEN-1:0] base, input logic [`LSQ_XLEN-1:0] off,
			input logic waiting, input logic [`LSQ_TAG_W-1:0] tag);
		lsq_dispatch_s d;
		d            = '0;
		d.op         = LOAD;
		d.base       = base;
		d.data_ready = 1'b1;
		if (waiting) begin
			d.offset.tv.pad = '0;
			d.offset.tv.tag = tag;
		end else begin
			d.offset.data  = off;
			d.offset_ready = 1'b1;
		end
		dispatch_item(d, ref_result(LOAD, base, off));
	endtask

	task automatic send_store(input logic [`LSQ_XLEN-1:0] base, input logic [`LSQ_XLEN-1:0] off,
			input logic [`LSQ_XLEN-1:0] data);
		lsq_dispatch_s d;
		d                 = '0;
		d.op              = STORE;
		d.base            = base;
		d.offset.data     = off;
		d.offset_ready    = 1'b1;
		d.store_data.data = data;
		d.data_ready      = 1'b1;
		dispatch_item(d, '0);
		spec_q.push_back(store_rec_s'{base + off, data});
	endtask

	task automatic broadcast(input logic [`LSQ_TAG_W-1:0] tag, input logic [`LSQ_XLEN-1:0] data);
		cdb.valid = 1'b1;
		cdb.tag   = tag;
		cdb.data  = data;
		idle(1);
		cdb = '0;
	endtask

	task automatic commit_pulse();
		store_rec_s rec;
		commit_store = 1'b1;
		idle(1);
		commit_store = 1'b0;
		if (spec_q.size() > 0) begin
			rec = spec_q.pop_front();
			ref_mem[rec.addr] = rec.data;
		end
	endtask

	// Outstanding loads and uncommitted stores are gone after a flush
	task automatic flush_pulse();
		flush = 1'b1;
		for (int i = 0; i < ROB_N; i++) begin
			if (exp_is_load[i]) exp_valid[i] = 1'b0;
		end
		spec_q.delete();
		idle(1);
		flush = 1'b0;
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (pending_results() != 0 && n < 200) begin
			idle(1);
			n++;
		end
		if (pending_results() != 0) begin
			other_errs++;
			$display("Results never arrived for %0d dispatched items", pending_results());
		end
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (mem_writes < count && n < 200) begin
			idle(1);
			n++;
		end
		if (mem_writes < count) begin
			other_errs++;
			$display("Only %0d of %0d store writes reached memory", mem_writes, count);
		end
	endtask

	task automatic wait_req();
		int n;
		n = 0;
		while (mem_req.valid !== 1'b1 && n < 50) begin
			idle(1);
			n++;
		end
		if (mem_req.valid !== 1'b1) begin
			other_errs++;
			$display("No memory request was raised for the head load");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model, compare process and watchdog
	////////////////////////////////////////////////////////////////////////////
	initial begin : memory_model
		int                   rsp_wait;
		logic [`LSQ_XLEN-1:0] rsp_data;
		logic [31:0]          rnd;
		mem_req_ready = 1'b0;
		mem_rsp       = '0;
		rsp_wait      = 0;
		rsp_data      = '0;
		forever begin
			@(posedge clock);
			if (!reset && mem_req.valid === 1'b1 && mem_req_ready) begin
				if (mem_req.is_store) begin
					mem[mem_req.addr] = mem_req.data;
					mem_writes++;
				end else begin
					rnd      = lcg_next();
					rsp_wait = 1 + rnd[17:16];     // 1 to 4 cycles
					rsp_data = read_mem(mem_req.addr);
				end
			end
			#10;
			mem_rsp = '0;
			if (rsp_wait > 0) begin
				rsp_wait--;
				if (rsp_wait == 0) begin
					mem_rsp.valid = 1'b1;
					mem_rsp.data  = rsp_data;
				end
			end
			rnd           = lcg_next();
			mem_req_ready = !hold_low && (rnd[19:18] != 2'b00);
		end
	end

	always @(posedge clock) begin : compare_results
		logic [`LSQ_ROB_W-1:0] r;
		if (!reset && result.valid === 1'b1) begin
			r = result.rob_idx;
			if (!exp_valid[r]) begin
				other_errs++;
				$display("Unexpected result for ROB index %0d at %0t", r, $time);
			end else begin
				check_eq(result.data, exp_data[r], $sformatf("data of ROB %0d", r));
				check_eq(result.dest_tag, exp_tag[r], $sformatf("tag of ROB %0d", r));
				if (exp_lda[r]) begin
					check_eq($time, exp_time[r] + CLK_PERIOD, $sformatf("LDA time of ROB %0d", r));
				end
				exp_valid[r] = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(ITEMS * 200 * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", ITEMS * 200);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin : main_seq
		lsq_mem_req_s snap;
		int           n;
		logic         seen;
		dispatch     = '0;
		cdb          = '0;
		commit_store = 1'b0;
		flush        = 1'b0;
		hold_low     = 1'b0;
		reset        = 1'b1;
		for (int i = 0; i < ROB_N; i++) begin
			exp_valid[i]   = 1'b0;
			exp_is_load[i] = 1'b0;
		end
		repeat (4) @(posedge clock);
		#10;
		reset = 1'b0;
		check_eq(result.valid, 1'b0, "result valid after reset");
		check_eq(mem_req.valid, 1'b0, "mem_req valid after reset");
		check_eq(dispatch_ready, 1'b1, "dispatch_ready after reset");

		// LDA back to back
		send_lda(64'h0000_1000, 64'h24);
		send_lda(64'hffff_ffff_ffff_fff0, 64'h20);      // Wraps around
		send_lda(64'h1234_5678_9abc_def0, 64'h0102_0304);
		wait_results();

		// Offset woken by a later broadcast, then by one in the dispatch cycle
		send_load(64'h1000, 64'h28, 1'b1, 6'd50);
		idle(3);
		broadcast(6'd50, 64'h28);
		wait_results();
		cdb.valid = 1'b1;
		cdb.tag   = 6'd51;
		cdb.data  = 64'h40;
		send_load(64'h2000, 64'h40, 1'b1, 6'd51);
		cdb = '0;
		wait_results();

		// Younger load waits for the older store to commit and write
		send_store(64'h3000, 64'h8, 64'hdead_beef_0123_4567);
		send_load(64'h3000, 64'h8, 1'b0, '0);
		idle(4);
		check_eq(pending_results(), 1, "load held behind uncommitted store");
		commit_pulse();
		wait_results();
		wait_writes(1);
		check_eq(read_mem(64'h3008), 64'hdead_beef_0123_4567, "memory after store");

		// Stalled memory and a full load queue
		hold_low      = 1'b1;
		mem_req_ready = 1'b0;
		send_load(64'h7000, 64'h0, 1'b0, '0);
		wait_req();
		snap = mem_req;
		for (int i = 0; i < 5; i++) begin
			idle(1);
			check_eq(mem_req.valid, snap.valid, "held mem_req valid");
			check_eq(mem_req.addr, snap.addr, "held mem_req addr");
			check_eq(mem_req.data, snap.data, "held mem_req data");
			check_eq(mem_req.is_store, snap.is_store, "held mem_req kind");
		end
		for (int i = 1; i < 8; i++) begin
			send_load(64'h7000 + 64'(8 * i), 64'h0, 1'b0, '0);
		end
		check_eq(dispatch_ready, 1'b0, "dispatch_ready with 8 loads queued");
		hold_low = 1'b0;
		seen     = 1'b0;
		n        = 0;
		while (!seen && n < 200) begin
			@(posedge clock);
			if (result.valid === 1'b1) begin
				seen = 1'b1;
			end else if (dispatch_ready !== 1'b0) begin
				other_errs++;
				$display("dispatch_ready rose before a load result freed an entry");
				seen = 1'b1;
			end
			#10;
			n++;
		end
		check_eq(dispatch_ready, 1'b1, "dispatch_ready after a load result");
		wait_results();

		// Flush with a load in flight, one committed and one speculative store
		hold_low      = 1'b1;
		mem_req_ready = 1'b0;
		send_load(64'h6010, 64'h0, 1'b0, '0);
		wait_req();
		send_store(64'h5000, 64'h0, 64'h0a0a_5555_0a0a_5555);
		send_store(64'h5008, 64'h0, 64'h7777_1111_7777_1111);
		commit_pulse();
		send_load(64'h6000, 64'h0, 1'b1, 6'd55);      // Offset never arrives
		flush_pulse();
		send_load(64'h6020, 64'h0, 1'b0, '0);         // Queued before the stale response returns
		idle(2);
		hold_low = 1'b0;
		wait_writes(2);
		wait_results();
		idle(20);
		check_eq(read_mem(64'h5000), 64'h0a0a_5555_0a0a_5555, "committed store after flush");
		check_eq(mem.exists(64'h5008), 0, "flushed store reached memory");

		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: logic/load_queue.sv
/*
 * Load queue
 * Holds loads in program order, wakes offsets from the CDB, counts older
 * stores and keeps returned data until the head result is taken
 */
`timescale 1ns/1ps
`include "lsq_consts.svh"

module load_queue
	import lsq_pkg::*;
(
	input  logic                                 clock,
	input  logic                                 reset,
	input  lsq_dispatch_s                        dispatch,
	input  lsq_cdb_s                             cdb,
	input  logic                                 flush,
	input  logic                                 store_written,
	input  logic [$clog2(`LSQ_SQ_DEPTH+1)-1:0]   sq_pending,
	output logic                                 issue_ok,
	output logic [`LSQ_XLEN-1:0]                 issue_addr,
	input  logic                                 load_data_valid,
	input  logic [`LSQ_XLEN-1:0]                 load_data,
	output lsq_result_s                          head_result,
	input  logic                                 load_taken,
	output logic                                 full
);
	localparam int DEPTH    = `LSQ_LQ_DEPTH;
	localparam int PTR_W    = $clog2(DEPTH);
	localparam int SQ_CNT_W = $clog2(`LSQ_SQ_DEPTH + 1);

	////////////////////////////////////////////////////////////////////////////
	// Entry storage
	////////////////////////////////////////////////////////////////////////////
	logic [`LSQ_XLEN-1:0]  base [DEPTH];
	lsq_operand_u          offset [DEPTH];
	logic [DEPTH-1:0]      offset_ready;
	logic [SQ_CNT_W-1:0]   st_cnt [DEPTH];    // Older stores still unwritten
	logic [DEPTH-1:0]      data_valid;
	logic [`LSQ_XLEN-1:0]  ldata [DEPTH];
	logic [`LSQ_ROB_W-1:0] rob_idx [DEPTH];
	logic [`LSQ_TAG_W-1:0] dest_tag [DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic             empty;
	logic             push;
	lsq_operand_u     in_offset;
	logic             in_offset_ready;

	assign push = (dispatch.op == LOAD) && !flush;

	queue_ptr_counter #(.DEPTH(DEPTH)) u_ptr (
		.clock        (clock),
		.reset        (reset),
		.push         (push),
		.pop          (load_taken),
		.rewind       (flush),
		.rewind_count ('0),       // Flush drops every load
		.head         (head),
		.tail         (tail),
		.full         (full),
		.empty        (empty)
	);

	// Same-cycle CDB capture at dispatch
	always_comb begin
		in_offset       = dispatch.offset;
		in_offset_ready = dispatch.offset_ready;
		if (!dispatch.offset_ready && cdb.valid && cdb.tag == dispatch.offset.tv.tag) begin
			in_offset.data  = cdb.data;
			in_offset_ready = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (!offset_ready[i] && cdb.valid && cdb.tag == offset[i].tv.tag) begin
				offset[i].data  <= cdb.data;
				offset_ready[i] <= 1'b1;
			end
			if (store_written && st_cnt[i] != '0) begin
				st_cnt[i] <= st_cnt[i] - 1'b1;
			end
		end
		if (load_data_valid) begin
			ldata[head]      <= load_data;
			data_valid[head] <= 1'b1;
		end
		if (push) begin
			base[tail]         <= dispatch.base;
			offset[tail]       <= in_offset;
			offset_ready[tail] <= in_offset_ready;
			st_cnt[tail]       <= sq_pending - store_written;
			data_valid[tail]   <= 1'b0;
			rob_idx[tail]      <= dispatch.rob_idx;
			dest_tag[tail]     <= dispatch.dest_tag;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Head issue and result
	////////////////////////////////////////////////////////////////////////////
	assign issue_ok   = !empty && offset_ready[head] && (st_cnt[head] == '0) && !data_valid[head];
	assign issue_addr = base[head] + offset[head].data;

	always_comb begin
		head_result.valid    = !empty && data_valid[head] && !flush;
		head_result.dest_tag = dest_tag[head];
		head_result.rob_idx  = rob_idx[head];
		head_result.data     = ldata[head];
	end

endmodule

// File: logic/lsq_consts.svh
/*
 * Load/store queue constants
 * Queue depths and field widths for the package and the RTL
 */
`ifndef LSQ_CONSTS_SVH
`define LSQ_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Queue depths, kept at powers of two so the pointers wrap naturally
////////////////////////////////////////////////////////////////////////////
`define LSQ_LQ_DEPTH 8
`define LSQ_SQ_DEPTH 8

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////
`define LSQ_TAG_W 6     // Physical register tag
`define LSQ_ROB_W 5     // ROB index
`define LSQ_XLEN 64     // Data and address

`endif

// File: logic/lsq_pkg.sv
/*
 * Load/store queue types
 * Operation code, the tag/data operand word and the bus structs
 */
`include "lsq_consts.svh"

package lsq_pkg;

	typedef enum logic [1:0] {
		NONE  = 2'd0,
		LOAD  = 2'd1,
		STORE = 2'd2,
		LDA   = 2'd3
	} lsq_op_e;

	// Tag view of an operand that is still waiting
	typedef struct packed {
		logic [`LSQ_XLEN-`LSQ_TAG_W-1:0] pad;
		logic [`LSQ_TAG_W-1:0]           tag;
	} lsq_tag_view_s;

	// Companion ready bit selects the view
	typedef union packed {
		logic [`LSQ_XLEN-1:0] data;
		lsq_tag_view_s        tv;
	} lsq_operand_u;

	typedef struct packed {
		lsq_op_e               op;
		logic [`LSQ_ROB_W-1:0] rob_idx;
		logic [`LSQ_TAG_W-1:0] dest_tag;
		logic [`LSQ_XLEN-1:0]  base;          // Always ready
		lsq_operand_u          offset;
		logic                  offset_ready;
		lsq_operand_u          store_data;
		logic                  data_ready;
	} lsq_dispatch_s;

	typedef struct packed {
		logic                  valid;
		logic [`LSQ_TAG_W-1:0] tag;
		logic [`LSQ_XLEN-1:0]  data;
	} lsq_cdb_s;

	typedef struct packed {
		logic                  valid;
		logic [`LSQ_TAG_W-1:0] dest_tag;
		logic [`LSQ_ROB_W-1:0] rob_idx;
		logic [`LSQ_XLEN-1:0]  data;
	} lsq_result_s;

	typedef struct packed {
		logic                 valid;
		logic                 is_store;
		logic [`LSQ_XLEN-1:0] addr;
		logic [`LSQ_XLEN-1:0] data;
	} lsq_mem_req_s;

	typedef struct packed {
		logic                 valid;
		logic [`LSQ_XLEN-1:0] data;
	} lsq_mem_rsp_s;

endpackage

// File: logic/lsq_top.sv
/*
 * Load/store queue top level
 * Connects the load and store queues, the memory issue FSM and the result arbiter
 */
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_top
	import lsq_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  lsq_dispatch_s dispatch,
	output logic          dispatch_ready,
	input  lsq_cdb_s      cdb,
	input  logic          commit_store,
	input  logic          flush,
	output lsq_result_s   result,
	output lsq_mem_req_s  mem_req,
	input  logic          mem_req_ready,
	input  lsq_mem_rsp_s  mem_rsp
);
	localparam int SQ_CNT_W = $clog2(`LSQ_SQ_DEPTH + 1);

	lsq_dispatch_s        dispatch_acc;     // Dispatch as seen by the queues
	logic                 lq_full;
	logic                 sq_full;
	logic [SQ_CNT_W-1:0]  sq_pending;
	logic                 sq_head_ready;
	logic [`LSQ_XLEN-1:0] sq_head_addr;
	logic [`LSQ_XLEN-1:0] sq_head_data;
	logic                 lq_issue_ok;
	logic [`LSQ_XLEN-1:0] lq_issue_addr;
	logic                 store_written;
	logic                 load_data_valid;
	logic [`LSQ_XLEN-1:0] load_data;
	lsq_result_s          lq_head_result;
	logic                 load_taken;

	assign dispatch_ready = !(lq_full || sq_full);

	// Nothing is written while dispatch is stalled
	always_comb begin
		dispatch_acc    = dispatch;
		dispatch_acc.op = dispatch_ready ? dispatch.op : NONE;
	end

	load_queue u_load_queue (
		.clock           (clock),
		.reset           (reset),
		.dispatch        (dispatch_acc),
		.cdb             (cdb),
		.flush           (flush),
		.store_written   (store_written),
		.sq_pending      (sq_pending),
		.issue_ok        (lq_issue_ok),
		.issue_addr      (lq_issue_addr),
		.load_data_valid (load_data_valid),
		.load_data       (load_data),
		.head_result     (lq_head_result),
		.load_taken      (load_taken),
		.full            (lq_full)
	);

	store_queue u_store_queue (
		.clock         (clock),
		.reset         (reset),
		.dispatch      (dispatch_acc),
		.cdb           (cdb),
		.flush         (flush),
		.commit_store  (commit_store),
		.store_written (store_written),
		.head_ready    (sq_head_ready),
		.head_addr     (sq_head_addr),
		.head_data     (sq_head_data),
		.pending       (sq_pending),
		.full          (sq_full)
	);

	mem_issue_fsm u_mem_issue_fsm (
		.clock            (clock),
		.reset            (reset),
		.flush            (flush),
		.store_head_ready (sq_head_ready),
		.store_addr       (sq_head_addr),
		.store_data       (sq_head_data),
		.load_issue_ok    (lq_issue_ok),
		.load_addr        (lq_issue_addr),
		.mem_req          (mem_req),
		.mem_req_ready    (mem_req_ready),
		.mem_rsp          (mem_rsp),
		.store_written    (store_written),
		.load_data_valid  (load_data_valid),
		.load_data        (load_data)
	);

	result_arbiter u_result_arbiter (
		.clock       (clock),
		.reset       (reset),
		.dispatch    (dispatch_acc),
		.load_result (lq_head_result),
		.load_taken  (load_taken),
		.result      (result)
	);

endmodule

// File: logic/mem_issue_fsm.sv
/*
 * Memory issue state machine
 * Picks a committed store or else the head load and runs one access at a time
 */
`timescale 1ns/1ps
`include "lsq_consts.svh"

module mem_issue_fsm
	import lsq_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 store_head_ready,
	input  logic [`LSQ_XLEN-1:0] store_addr,
	input  logic [`LSQ_XLEN-1:0] store_data,
	input  logic                 load_issue_ok,
	input  logic [`LSQ_XLEN-1:0] load_addr,
	output lsq_mem_req_s         mem_req,
	input  logic                 mem_req_ready,
	input  lsq_mem_rsp_s         mem_rsp,
	output logic                 store_written,
	output logic                 load_data_valid,
	output logic [`LSQ_XLEN-1:0] load_data
);
	typedef enum logic [1:0] {
		IDLE,
		STORE_REQ,
		LOAD_REQ,
		LOAD_WAIT
	} state_e;

	state_e               state;
	logic                 drop;     // Outstanding load was flushed
	logic [`LSQ_XLEN-1:0] req_addr;
	logic [`LSQ_XLEN-1:0] req_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			drop  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (store_head_ready) begin
						state <= STORE_REQ;
					end else if (load_issue_ok && !flush) begin
						state <= LOAD_REQ;
					end
				end
				STORE_REQ: if (mem_req_ready) state <= IDLE;
				LOAD_REQ:  if (mem_req_ready) state <= LOAD_WAIT;
				LOAD_WAIT: if (mem_rsp.valid) state <= IDLE;
				default:   state <= IDLE;
			endcase
			if (state == LOAD_WAIT && mem_rsp.valid) begin
				drop <= 1'b0;
			end else if (flush && (state == LOAD_REQ || state == LOAD_WAIT)) begin
				drop <= 1'b1;
			end
		end
	end

	// Request payload is held while the FSM waits for ready
	always_ff @(posedge clock) begin
		if (state == IDLE) begin
			req_addr <= store_head_ready ? store_addr : load_addr;
			req_data <= store_data;
		end
	end

	always_comb begin
		mem_req.valid    = (state == STORE_REQ) || (state == LOAD_REQ);
		mem_req.is_store = (state == STORE_REQ);
		mem_req.addr     = req_addr;
		mem_req.data     = req_data;
	end

	assign store_written   = (state == STORE_REQ) && mem_req_ready;
	assign load_data_valid = (state == LOAD_WAIT) && mem_rsp.valid && !drop && !flush;
	assign load_data       = mem_rsp.data;

endmodule

// File: logic/queue_ptr_counter.sv
/*
 * Circular queue pointers
 * Head, tail and occupancy with full/empty, plus a tail rewind for flush
 */
`timescale 1ns/1ps

module queue_ptr_counter #(
	parameter int DEPTH = 8
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       push,
	input  logic                       pop,
	input  logic                       rewind,
	input  logic [$clog2(DEPTH+1)-1:0] rewind_count,    // Entries kept after this pop
	output logic [$clog2(DEPTH)-1:0]   head,
	output logic [$clog2(DEPTH)-1:0]   tail,
	output logic                       full,
	output logic                       empty
);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	logic [CNT_W-1:0]         count;
	logic [$clog2(DEPTH)-1:0] head_next;

	assign head_next = head + pop;

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (rewind) begin
			head  <= head_next;
			tail  <= head_next + rewind_count[$clog2(DEPTH)-1:0];
			count <= rewind_count;
		end else begin
			head  <= head_next;
			tail  <= tail + push;
			count <= count + push - pop;
		end
	end

	assign full  = (count == FULL_CNT);
	assign empty = (count == '0);

endmodule

// File: logic/result_arbiter.sv
/*
 * Result bus arbiter
 * LDA sums go out one cycle after dispatch, finished loads fill the gaps
 */
`timescale 1ns/1ps
`include "lsq_consts.svh"

module result_arbiter
	import lsq_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  lsq_dispatch_s dispatch,
	input  lsq_result_s   load_result,
	output logic          load_taken,
	output lsq_result_s   result
);
	logic                  lda_valid;
	logic [`LSQ_TAG_W-1:0] lda_tag;
	logic [`LSQ_ROB_W-1:0] lda_rob;
	logic [`LSQ_XLEN-1:0]  lda_sum;

	always_ff @(posedge clock) begin
		if (reset) lda_valid <= 1'b0;
		else       lda_valid <= (dispatch.op == LDA);
	end

	always_ff @(posedge clock) begin
		if (dispatch.op == LDA) begin
			lda_tag <= dispatch.dest_tag;
			lda_rob <= dispatch.rob_idx;
			lda_sum <= dispatch.base + dispatch.offset.data;   // Offset is always ready
		end
	end

	// LDA has priority on the single bus
	always_comb begin
		if (lda_valid) begin
			result.valid    = 1'b1;
			result.dest_tag = lda_tag;
			result.rob_idx  = lda_rob;
			result.data     = lda_sum;
		end else begin
			result = load_result;
		end
	end

	assign load_taken = !lda_valid && load_result.valid;

endmodule

// File: logic/store_queue.sv
/*
 * Store queue
 * Holds stores in program order, wakes address and data operands from the
 * CDB and releases committed stores at the head to memory
 */
`timescale 1ns/1ps
`include "lsq_consts.svh"

module store_queue
	import lsq_pkg::*;
(
	input  logic                               clock,
	input  logic                               reset,
	input  lsq_dispatch_s                      dispatch,
	input  lsq_cdb_s                           cdb,
	input  logic                               flush,
	input  logic                               commit_store,
	input  logic                               store_written,
	output logic                               head_ready,
	output logic [`LSQ_XLEN-1:0]               head_addr,
	output logic [`LSQ_XLEN-1:0]               head_data,
	output logic [$clog2(`LSQ_SQ_DEPTH+1)-1:0] pending,
	output logic                               full
);
	localparam int DEPTH = `LSQ_SQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`LSQ_XLEN-1:0] base [DEPTH];
	lsq_operand_u         offset [DEPTH];
	logic [DEPTH-1:0]     offset_ready;
	lsq_operand_u         sdata [DEPTH];
	logic [DEPTH-1:0]     data_ready;

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] occ;
	logic             empty;
	logic             push;
	logic [CNT_W-1:0] commit_cnt;       // Committed but not yet written
	logic [CNT_W-1:0] commit_next;

	// Operand with same-cycle CDB capture
	function automatic lsq_operand_u wake(lsq_operand_u op, logic rdy, lsq_cdb_s bus);
		lsq_operand_u res;
		res = op;
		if (!rdy && bus.valid && bus.tag == op.tv.tag) res.data = bus.data;
		return res;
	endfunction

	function automatic logic woken(lsq_operand_u op, logic rdy, lsq_cdb_s bus);
		return rdy || (bus.valid && bus.tag == op.tv.tag);
	endfunction

	assign push        = (dispatch.op == STORE) && !flush;
	assign commit_next = commit_cnt + commit_store - store_written;

	queue_ptr_counter #(.DEPTH(DEPTH)) u_ptr (
		.clock        (clock),
		.reset        (reset),
		.push         (push),
		.pop          (store_written),
		.rewind       (flush),
		.rewind_count (commit_next),    // Keep only committed stores
		.head         (head),
		.tail         (tail),
		.full         (full),
		.empty        (empty)
	);

	always_ff @(posedge clock) begin
		if (reset) commit_cnt <= '0;
		else       commit_cnt <= commit_next;
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < DEPTH; i++) begin
			offset[i]       <= wake(offset[i], offset_ready[i], cdb);
			offset_ready[i] <= woken(offset[i], offset_ready[i], cdb);
			sdata[i]        <= wake(sdata[i], data_ready[i], cdb);
			data_ready[i]   <= woken(sdata[i], data_ready[i], cdb);
		end
		if (push) begin
			base[tail]         <= dispatch.base;
			offset[tail]       <= wake(dispatch.offset, dispatch.offset_ready, cdb);
			offset_ready[tail] <= woken(dispatch.offset, dispatch.offset_ready, cdb);
			sdata[tail]        <= wake(dispatch.store_data, dispatch.data_ready, cdb);
			data_ready[tail]   <= woken(dispatch.store_data, dispatch.data_ready, cdb);
		end
	end

	assign occ        = tail - head;
	assign pending    = full ? CNT_W'(DEPTH) : {1'b0, occ};
	assign head_ready = !empty && (commit_cnt != '0) && offset_ready[head] && data_ready[head];
	assign head_addr  = base[head] + offset[head].data;
	assign head_data  = sdata[head].data;

endmodule

// File: project.f
+incdir+logic
logic/lsq_pkg.sv
logic/queue_ptr_counter.sv
logic/mem_issue_fsm.sv
logic/load_queue.sv
logic/store_queue.sv
logic/result_arbiter.sv
logic/lsq_top.sv
dv/lsq_tb.sv
